// ==== verilog/bfis_params.svh ====
`ifndef BFIS_PARAMS_SVH
`define BFIS_PARAMS_SVH

// vector dimension of the query and of every vertex
`define BFIS_DIM 4

// vertices in the fixed graph
`define BFIS_NUM_VERTICES 16

// neighbours stored per vertex
`define BFIS_DEGREE 4

// slots in each sorted queue
`define BFIS_PQ_LENGTH 16

// bits of a vertex number, enough for BFIS_NUM_VERTICES
`define BFIS_ID_W 4

// unsigned coordinate width
`define BFIS_COORD_W 8

// squared distance, 4 * 255^2 = 260100 fits in 18 bits
`define BFIS_DIST_W 18

// width of k and of entry counts, holds 0 to 16
`define BFIS_K_W 5

`endif

// ==== verilog/graph_pkg.sv ====
`include "bfis_params.svh"

package graph_pkg;

  typedef logic [`BFIS_ID_W-1:0]    vertex_id_t;
  typedef logic [`BFIS_COORD_W-1:0] coord_t;
  typedef logic [`BFIS_DIST_W-1:0]  dist_t;

  // coordinate d of vertex v, low byte of v*37 + d*91 + 11
  function automatic coord_t vertex_coord(input vertex_id_t v, input int unsigned d);
    int unsigned raw;
    raw = int'(v) * 37 + d * 91 + 11;
    return coord_t'(raw);
  endfunction

  // ring plus stride-4 links, wraps modulo 16 through the id width
  function automatic vertex_id_t vertex_neighbor(input vertex_id_t v, input int unsigned j);
    vertex_id_t n;
    case (j)
      0:       n = v + vertex_id_t'(1);
      1:       n = v - vertex_id_t'(1);
      2:       n = v + vertex_id_t'(4);
      default: n = v - vertex_id_t'(4);
    endcase
    return n;
  endfunction

endpackage

// ==== verilog/search_pkg.sv ====
package search_pkg;

  // controller states
  // seed sends the entry vertex, pop picks the next candidate,
  // fetch issues neighbours, drain waits on the distance pipe
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_SEED,
    ST_POP,
    ST_FETCH,
    ST_DRAIN,
    ST_READOUT
  } search_state_t;

  // one operation per queue per cycle
  typedef enum logic [1:0] {
    OP_NOP,
    OP_INSERT,
    OP_POP
  } queue_op_t;

endpackage

// ==== verilog/graph_rom.sv ====
`timescale 1ns/1ps
`include "bfis_params.svh"

module graph_rom (
  input  graph_pkg::vertex_id_t                    addr,
  output graph_pkg::coord_t     [`BFIS_DIM-1:0]    coord,
  output graph_pkg::vertex_id_t [`BFIS_DEGREE-1:0] neighbors
);
  import graph_pkg::*;

  localparam int unsigned NV  = `BFIS_NUM_VERTICES;
  localparam int unsigned DIM = `BFIS_DIM;
  localparam int unsigned DEG = `BFIS_DEGREE;

  // one row per vertex
  coord_t     [DIM-1:0] coord_tab [NV];
  vertex_id_t [DEG-1:0] nbr_tab   [NV];

  // table is fixed at elaboration, every entry is a constant
  for (genvar v = 0; v < NV; v++) begin : g_vertex
    // coordinates from the closed-form rule
    for (genvar d = 0; d < DIM; d++) begin : g_dim
      assign coord_tab[v][d] = vertex_coord(vertex_id_t'(v), d);
    end
    // adjacency, slot order +1, -1, +4, -4
    for (genvar j = 0; j < DEG; j++) begin : g_nbr
      assign nbr_tab[v][j] = vertex_neighbor(vertex_id_t'(v), j);
    end
  end

  // asynchronous read
  assign coord     = coord_tab[addr];
  assign neighbors = nbr_tab[addr];

endmodule

// ==== verilog/l2_distance.sv ====
`timescale 1ns/1ps
`include "bfis_params.svh"

module l2_distance (
  input  logic                                 clk_100mhz,
  input  logic                                 sys_rst,
  input  logic                                 in_valid,
  input  graph_pkg::vertex_id_t                in_id,
  input  graph_pkg::coord_t     [`BFIS_DIM-1:0] a,
  input  graph_pkg::coord_t     [`BFIS_DIM-1:0] b,
  output logic                                 out_valid,
  output graph_pkg::vertex_id_t                out_id,
  output graph_pkg::dist_t                     out_dist
);
  import graph_pkg::*;

  localparam int unsigned DIM  = `BFIS_DIM;
  localparam int unsigned SQ_W = 2 * `BFIS_COORD_W;

  coord_t [DIM-1:0] diff;
  logic [SQ_W-1:0]  sq_q [DIM];
  logic             s1_valid_q;
  vertex_id_t       s1_id_q;
  dist_t            sum;

  // absolute difference per dimension, stays unsigned
  always_comb begin
    for (int d = 0; d < DIM; d++) begin
      diff[d] = (a[d] > b[d]) ? a[d] - b[d] : b[d] - a[d];
    end
  end

  // adder tree over the registered squares
  always_comb begin
    sum = '0;
    for (int d = 0; d < DIM; d++) begin
      sum = sum + dist_t'(sq_q[d]);
    end
  end

  // valid bits walk the two stages
  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      s1_valid_q <= 1'b0;
      out_valid  <= 1'b0;
    end else begin
      s1_valid_q <= in_valid;
      out_valid  <= s1_valid_q;
    end
  end

  // stage one squares, stage two sum
  // the id tag travels with its data
  always_ff @(posedge clk_100mhz) begin
    for (int d = 0; d < DIM; d++) begin
      sq_q[d] <= SQ_W'(diff[d]) * SQ_W'(diff[d]);
    end
    s1_id_q  <= in_id;
    out_id   <= s1_id_q;
    out_dist <= sum;
  end

endmodule

// ==== verilog/candidate_queue.sv ====
`timescale 1ns/1ps
`include "bfis_params.svh"

module candidate_queue (
  input  logic                  clk_100mhz,
  input  logic                  sys_rst,
  input  logic                  clear,
  input  search_pkg::queue_op_t op,
  input  graph_pkg::vertex_id_t ins_id,
  input  graph_pkg::dist_t      ins_dist,
  output graph_pkg::vertex_id_t head_id,
  output graph_pkg::dist_t      head_dist,
  output logic                  empty
);
  import graph_pkg::*;
  import search_pkg::*;

  localparam int unsigned LEN = `BFIS_PQ_LENGTH;

  // slot 0 holds the smallest distance
  vertex_id_t     id_q   [LEN];
  dist_t          dist_q [LEN];
  vertex_id_t     id_d   [LEN];
  dist_t          dist_d [LEN];
  logic [LEN-1:0] valid_q;
  logic [LEN-1:0] valid_d;
  // slot is free or strictly larger, new entry lands at or before it
  logic [LEN-1:0] after;

  always_comb begin
    // strict compare, equal distances keep the older entry ahead
    for (int i = 0; i < LEN; i++) begin
      after[i] = !valid_q[i] || (dist_q[i] > ins_dist);
    end
    id_d    = id_q;
    dist_d  = dist_q;
    valid_d = valid_q;
    case (op)
      OP_INSERT: begin
        if (after[0]) begin
          id_d[0]    = ins_id;
          dist_d[0]  = ins_dist;
          valid_d[0] = 1'b1;
        end
        // larger slots move down one, the first of them takes the new entry
        for (int i = 1; i < LEN; i++) begin
          if (after[i] && after[i-1]) begin
            id_d[i]    = id_q[i-1];
            dist_d[i]  = dist_q[i-1];
            valid_d[i] = valid_q[i-1];
          end else if (after[i]) begin
            id_d[i]    = ins_id;
            dist_d[i]  = ins_dist;
            valid_d[i] = 1'b1;
          end
        end
      end
      OP_POP: begin
        // everything moves up, tail becomes free
        for (int i = 0; i < LEN - 1; i++) begin
          id_d[i]    = id_q[i+1];
          dist_d[i]  = dist_q[i+1];
          valid_d[i] = valid_q[i+1];
        end
        valid_d[LEN-1] = 1'b0;
      end
      default: begin
      end
    endcase
  end

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst || clear) begin
      valid_q <= '0;
    end else begin
      valid_q <= valid_d;
    end
  end

  always_ff @(posedge clk_100mhz) begin
    id_q   <= id_d;
    dist_q <= dist_d;
  end

  assign head_id   = id_q[0];
  assign head_dist = dist_q[0];
  assign empty     = !valid_q[0];

endmodule

// ==== verilog/result_queue.sv ====
`timescale 1ns/1ps
`include "bfis_params.svh"

module result_queue (
  input  logic                  clk_100mhz,
  input  logic                  sys_rst,
  input  logic                  clear,
  input  logic [`BFIS_K_W-1:0]  k,
  input  search_pkg::queue_op_t op,
  input  graph_pkg::vertex_id_t ins_id,
  input  graph_pkg::dist_t      ins_dist,
  output graph_pkg::vertex_id_t head_id,
  output graph_pkg::dist_t      head_dist,
  output graph_pkg::dist_t      worst_dist,
  output logic                  full,
  output logic [`BFIS_K_W-1:0]  count
);
  import graph_pkg::*;
  import search_pkg::*;

  localparam int unsigned LEN   = `BFIS_PQ_LENGTH;
  localparam int unsigned K_W   = `BFIS_K_W;
  localparam int unsigned IDX_W = $clog2(LEN);

  vertex_id_t       id_q   [LEN];
  dist_t            dist_q [LEN];
  vertex_id_t       id_d   [LEN];
  dist_t            dist_d [LEN];
  logic [LEN-1:0]   valid_q;
  logic [LEN-1:0]   valid_d;
  logic [LEN-1:0]   after;
  // slots below the latched k
  logic [LEN-1:0]   cap;
  logic [K_W-1:0]   k_q;
  logic [IDX_W-1:0] worst_idx;

  always_comb begin
    for (int i = 0; i < LEN; i++) begin
      after[i] = !valid_q[i] || (dist_q[i] > ins_dist);
      cap[i]   = K_W'(i) < k_q;
    end
    id_d    = id_q;
    dist_d  = dist_q;
    valid_d = valid_q;
    case (op)
      OP_INSERT: begin
        if (after[0]) begin
          id_d[0]    = ins_id;
          dist_d[0]  = ins_dist;
          valid_d[0] = 1'b1;
        end
        for (int i = 1; i < LEN; i++) begin
          if (after[i] && after[i-1]) begin
            id_d[i]    = id_q[i-1];
            dist_d[i]  = dist_q[i-1];
            valid_d[i] = valid_q[i-1];
          end else if (after[i]) begin
            id_d[i]    = ins_id;
            dist_d[i]  = ins_dist;
            valid_d[i] = 1'b1;
          end
        end
        // whatever lands at slot k or beyond is the dropped worst
        valid_d = valid_d & cap;
      end
      OP_POP: begin
        // readout shifts the head out
        for (int i = 0; i < LEN - 1; i++) begin
          id_d[i]    = id_q[i+1];
          dist_d[i]  = dist_q[i+1];
          valid_d[i] = valid_q[i+1];
        end
        valid_d[LEN-1] = 1'b0;
      end
      default: begin
      end
    endcase
  end

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      valid_q <= '0;
      count   <= '0;
      k_q     <= K_W'(LEN);
    end else if (clear) begin
      // new search, capacity taken from k
      valid_q <= '0;
      count   <= '0;
      k_q     <= k;
    end else begin
      valid_q <= valid_d;
      case (op)
        OP_INSERT: if (!full) count <= count + 1'b1;
        OP_POP:    if (count != '0) count <= count - 1'b1;
        default: begin
        end
      endcase
    end
  end

  always_ff @(posedge clk_100mhz) begin
    id_q   <= id_d;
    dist_q <= dist_d;
  end

  // k-th slot, only meaningful once full
  assign worst_idx  = IDX_W'(k_q - K_W'(1));
  assign worst_dist = dist_q[worst_idx];
  assign full       = (count == k_q);
  assign head_id    = id_q[0];
  assign head_dist  = dist_q[0];

endmodule

// ==== verilog/search_ctrl.sv ====
`timescale 1ns/1ps
`include "bfis_params.svh"

module search_ctrl (
  input  logic                                     clk_100mhz,
  input  logic                                     sys_rst,
  input  logic                                     start,
  input  graph_pkg::vertex_id_t                    entry_id,
  input  graph_pkg::coord_t     [`BFIS_DIM-1:0]    query,
  input  logic                  [`BFIS_K_W-1:0]    k,
  output graph_pkg::vertex_id_t                    rom_addr,
  input  graph_pkg::coord_t     [`BFIS_DIM-1:0]    rom_coord,
  input  graph_pkg::vertex_id_t [`BFIS_DEGREE-1:0] rom_neighbors,
  output logic                                     dist_valid,
  output graph_pkg::vertex_id_t                    dist_id,
  output graph_pkg::coord_t     [`BFIS_DIM-1:0]    dist_query,
  output graph_pkg::coord_t     [`BFIS_DIM-1:0]    dist_coord,
  input  logic                                     pipe_valid,
  output search_pkg::queue_op_t                    cq_op,
  input  graph_pkg::vertex_id_t                    cq_head_id,
  input  graph_pkg::dist_t                         cq_head_dist,
  input  logic                                     cq_empty,
  output search_pkg::queue_op_t                    rq_op,
  output logic                                     rq_clear,
  input  graph_pkg::dist_t                         rq_worst,
  input  logic                                     rq_full,
  output logic                                     result_valid,
  output logic                                     done,
  output logic                                     busy
);
  import graph_pkg::*;
  import search_pkg::*;

  localparam int unsigned NV       = `BFIS_NUM_VERTICES;
  localparam int unsigned DEG      = `BFIS_DEGREE;
  localparam int unsigned K_W      = `BFIS_K_W;
  localparam int unsigned J_W      = $clog2(DEG);
  localparam int unsigned FLIGHT_W = $clog2(DEG + 1);

  search_state_t          state_q;
  search_state_t          state_d;
  coord_t [`BFIS_DIM-1:0] query_q;
  vertex_id_t             entry_q;
  logic [K_W-1:0]         k_q;
  // one bit per vertex, set when its distance is issued
  logic [NV-1:0]          visited_q;
  // neighbour list of the vertex under expansion
  vertex_id_t [DEG-1:0]   nbr_q;
  logic [J_W-1:0]         nbr_idx_q;
  // items inside the distance pipe
  logic [FLIGHT_W-1:0]    inflight_q;
  // distinct vertices sent to the queues
  logic [K_W-1:0]         reached_q;
  // results still to stream out
  logic [K_W-1:0]         left_q;
  logic                   stop;

  // nothing left, or the best candidate cannot beat the k-th result
  assign stop = cq_empty || (rq_full && (cq_head_dist > rq_worst));

  // pop reads the head's adjacency, fetch reads each neighbour's coordinates
  always_comb begin
    case (state_q)
      ST_POP:   rom_addr = cq_head_id;
      ST_FETCH: rom_addr = nbr_q[nbr_idx_q];
      default:  rom_addr = entry_q;
    endcase
  end

  // pipe gets the held query and the addressed vertex
  assign dist_id    = rom_addr;
  assign dist_query = query_q;
  assign dist_coord = rom_coord;
  // skip neighbours already issued
  assign dist_valid = (state_q == ST_SEED) ||
                      ((state_q == ST_FETCH) && !visited_q[rom_addr]);

  // pipe output feeds both queues in the same cycle
  // pops never overlap an insert, pop waits for drain
  always_comb begin
    cq_op = OP_NOP;
    rq_op = OP_NOP;
    if (pipe_valid) begin
      cq_op = OP_INSERT;
      rq_op = OP_INSERT;
    end else if (state_q == ST_POP && !stop) begin
      cq_op = OP_POP;
    end else if (state_q == ST_READOUT) begin
      rq_op = OP_POP;
    end
  end

  // start ignored while busy
  assign rq_clear     = (state_q == ST_IDLE) && start;
  assign busy         = (state_q != ST_IDLE);
  assign result_valid = (state_q == ST_READOUT);
  assign done         = result_valid && (left_q == K_W'(1));

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE:    if (start) state_d = ST_SEED;
      ST_SEED:    state_d = ST_DRAIN;
      ST_POP:     state_d = stop ? ST_READOUT : ST_FETCH;
      ST_FETCH:   if (nbr_idx_q == J_W'(DEG - 1)) state_d = ST_DRAIN;
      ST_DRAIN:   if (inflight_q == '0) state_d = ST_POP;
      ST_READOUT: if (done) state_d = ST_IDLE;
      default:    state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      state_q    <= ST_IDLE;
      visited_q  <= '0;
      nbr_idx_q  <= '0;
      inflight_q <= '0;
      reached_q  <= '0;
      left_q     <= '0;
    end else begin
      state_q    <= state_d;
      inflight_q <= inflight_q + FLIGHT_W'(dist_valid) - FLIGHT_W'(pipe_valid);
      if (rq_clear) begin
        visited_q <= '0;
        reached_q <= '0;
      end else if (dist_valid) begin
        visited_q[rom_addr] <= 1'b1;
        reached_q           <= reached_q + 1'b1;
      end
      // walk neighbour slots one per cycle
      if (state_q == ST_FETCH) begin
        nbr_idx_q <= nbr_idx_q + 1'b1;
      end else begin
        nbr_idx_q <= '0;
      end
      // readout length is min(k, reached)
      if (state_q == ST_POP && stop) begin
        left_q <= (reached_q < k_q) ? reached_q : k_q;
      end else if (result_valid) begin
        left_q <= left_q - 1'b1;
      end
    end
  end

  // search arguments and the expanded vertex's adjacency
  always_ff @(posedge clk_100mhz) begin
    if (rq_clear) begin
      query_q <= query;
      entry_q <= entry_id;
      k_q     <= k;
    end
    if (state_q == ST_POP) begin
      nbr_q <= rom_neighbors;
    end
  end

endmodule

// ==== verilog/bfis.sv ====
`timescale 1ns/1ps
`include "bfis_params.svh"

module bfis (
  input  logic                                  clk_100mhz,
  input  logic                                  sys_rst,
  input  logic                                  start,
  input  graph_pkg::vertex_id_t                 entry_id,
  input  graph_pkg::coord_t     [`BFIS_DIM-1:0] query,
  input  logic                  [`BFIS_K_W-1:0] k,
  output graph_pkg::vertex_id_t                 result_id,
  output graph_pkg::dist_t                      result_dist,
  output logic                                  result_valid,
  output logic                                  done,
  output logic                                  busy
);
  import graph_pkg::*;
  import search_pkg::*;

  // rom
  vertex_id_t                    rom_addr;
  coord_t     [`BFIS_DIM-1:0]    rom_coord;
  vertex_id_t [`BFIS_DEGREE-1:0] rom_neighbors;

  // distance pipe in and out
  logic                       dist_valid;
  vertex_id_t                 dist_id;
  coord_t     [`BFIS_DIM-1:0] dist_query;
  coord_t     [`BFIS_DIM-1:0] dist_coord;
  logic                       pipe_valid;
  vertex_id_t                 pipe_id;
  dist_t                      pipe_dist;

  // queues
  queue_op_t  cq_op;
  vertex_id_t cq_head_id;
  dist_t      cq_head_dist;
  logic       cq_empty;
  queue_op_t  rq_op;
  logic       rq_clear;
  dist_t      rq_worst;
  logic       rq_full;

  graph_rom u_rom (
    .addr      (rom_addr),
    .coord     (rom_coord),
    .neighbors (rom_neighbors)
  );

  l2_distance u_l2 (
    .clk_100mhz (clk_100mhz),
    .sys_rst    (sys_rst),
    .in_valid   (dist_valid),
    .in_id      (dist_id),
    .a          (dist_query),
    .b          (dist_coord),
    .out_valid  (pipe_valid),
    .out_id     (pipe_id),
    .out_dist   (pipe_dist)
  );

  // both queues clear together at start
  candidate_queue u_cq (
    .clk_100mhz (clk_100mhz),
    .sys_rst    (sys_rst),
    .clear      (rq_clear),
    .op         (cq_op),
    .ins_id     (pipe_id),
    .ins_dist   (pipe_dist),
    .head_id    (cq_head_id),
    .head_dist  (cq_head_dist),
    .empty      (cq_empty)
  );

  // head drives the result stream
  result_queue u_rq (
    .clk_100mhz (clk_100mhz),
    .sys_rst    (sys_rst),
    .clear      (rq_clear),
    .k          (k),
    .op         (rq_op),
    .ins_id     (pipe_id),
    .ins_dist   (pipe_dist),
    .head_id    (result_id),
    .head_dist  (result_dist),
    .worst_dist (rq_worst),
    .full       (rq_full),
    .count      ()
  );

  search_ctrl u_ctrl (
    .clk_100mhz    (clk_100mhz),
    .sys_rst       (sys_rst),
    .start         (start),
    .entry_id      (entry_id),
    .query         (query),
    .k             (k),
    .rom_addr      (rom_addr),
    .rom_coord     (rom_coord),
    .rom_neighbors (rom_neighbors),
    .dist_valid    (dist_valid),
    .dist_id       (dist_id),
    .dist_query    (dist_query),
    .dist_coord    (dist_coord),
    .pipe_valid    (pipe_valid),
    .cq_op         (cq_op),
    .cq_head_id    (cq_head_id),
    .cq_head_dist  (cq_head_dist),
    .cq_empty      (cq_empty),
    .rq_op         (rq_op),
    .rq_clear      (rq_clear),
    .rq_worst      (rq_worst),
    .rq_full       (rq_full),
    .result_valid  (result_valid),
    .done          (done),
    .busy          (busy)
  );

endmodule

// ==== verification/bfis_sva.sv ====
`timescale 1ns/1ps
`include "bfis_params.svh"

module bfis_sva (
  input logic             clk_100mhz,
  input logic             sys_rst,
  input logic             start,
  input graph_pkg::dist_t result_dist,
  input logic             result_valid,
  input logic             done,
  input logic             busy
);

  // set by the first start after reset
  logic        started_q;
  // read by the testbench at the end of the run
  int unsigned fail_count = 0;

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      started_q <= 1'b0;
    end else if (start) begin
      started_q <= 1'b1;
    end
  end

  // outputs quiet from reset until the first start
  a_quiet_after_reset: assert property (@(posedge clk_100mhz) disable iff (sys_rst)
    !started_q |-> !busy && !result_valid && !done)
  else begin
    fail_count++;
    $error("busy, result_valid or done active before the first start");
  end

  // accepted start raises busy next cycle
  a_busy_rises: assert property (@(posedge clk_100mhz) disable iff (sys_rst)
    start && !busy |=> busy)
  else begin
    fail_count++;
    $error("busy did not rise after an accepted start");
  end

  // done only alongside a result
  a_done_with_result: assert property (@(posedge clk_100mhz) disable iff (sys_rst)
    done |-> result_valid)
  else begin
    fail_count++;
    $error("done without result_valid");
  end

  // results back to back until done
  a_stream_unbroken: assert property (@(posedge clk_100mhz) disable iff (sys_rst)
    result_valid && !done |=> result_valid)
  else begin
    fail_count++;
    $error("gap in the result stream before done");
  end

  // ascending distance inside one stream
  a_ascending: assert property (@(posedge clk_100mhz) disable iff (sys_rst)
    result_valid && !done |=> result_dist >= $past(result_dist))
  else begin
    fail_count++;
    $error("result distances not in ascending order");
  end

  // stream ends with done, busy drops next cycle
  a_end_of_search: assert property (@(posedge clk_100mhz) disable iff (sys_rst)
    done |=> !busy && !result_valid)
  else begin
    fail_count++;
    $error("busy or result_valid still high after done");
  end

endmodule

bind bfis bfis_sva u_sva (.*);

// ==== verification/bfis_tb.sv ====
`timescale 1ns/1ps
`include "bfis_params.svh"

module bfis_tb;
  import graph_pkg::*;

  localparam int unsigned DIM          = `BFIS_DIM;
  localparam int unsigned NV           = `BFIS_NUM_VERTICES;
  localparam int unsigned K_W          = `BFIS_K_W;
  localparam int unsigned NUM_SEARCHES = 40;
  // generous cycle budget for one search
  localparam int unsigned SEARCH_BOUND = 400;

  logic             clk_100mhz = 1'b0;
  logic             sys_rst;
  logic             start;
  vertex_id_t       entry_id;
  coord_t [DIM-1:0] query;
  logic [K_W-1:0]   k;
  vertex_id_t       result_id;
  dist_t            result_dist;
  logic             result_valid;
  logic             done;
  logic             busy;

  logic [31:0]      lfsr;
  int unsigned      errors;
  int unsigned      searches_done;
  int unsigned      results_seen;

  // state of the search under check
  logic             armed;
  coord_t [DIM-1:0] exp_query;
  vertex_id_t       exp_entry;
  int unsigned      exp_k;
  logic             exact_query;
  logic [NV-1:0]    seen_ids;
  int unsigned      n_results;
  dist_t            last_dist;

  bfis dut (
    .clk_100mhz   (clk_100mhz),
    .sys_rst      (sys_rst),
    .start        (start),
    .entry_id     (entry_id),
    .query        (query),
    .k            (k),
    .result_id    (result_id),
    .result_dist  (result_dist),
    .result_valid (result_valid),
    .done         (done),
    .busy         (busy)
  );

  // 100 MHz
  always #5 clk_100mhz = !clk_100mhz;

  // fibonacci lfsr, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // one lfsr step per bit
  task automatic draw_bits(input int unsigned n, output logic [31:0] r);
    r = '0;
    for (int unsigned i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      r    = {r[30:0], lfsr[0]};
    end
  endtask

  // reference squared L2 from the graph coordinate rule
  function automatic int unsigned squared_l2(input coord_t [DIM-1:0] q, input vertex_id_t v);
    int          diff;
    int unsigned acc;
    acc = 0;
    for (int d = 0; d < DIM; d++) begin
      diff = int'(q[d]) - int'(vertex_coord(v, d));
      acc  = acc + diff * diff;
    end
    return acc;
  endfunction

  task automatic log_mismatch(input string msg);
    errors++;
    $display("MISMATCH at %0t: %s", $time, msg);
  endtask

  // one search: real start, then an ignored start with junk inputs
  task automatic run_search(input int unsigned idx);
    logic [31:0]      r;
    vertex_id_t       ent;
    coord_t [DIM-1:0] q;
    logic [K_W-1:0]   kv;
    draw_bits(4, r);
    ent = vertex_id_t'(r);
    draw_bits(4, r);
    kv = K_W'(r[3:0]) + K_W'(1);
    for (int d = 0; d < DIM; d++) begin
      draw_bits(8, r);
      q[d] = coord_t'(r);
    end
    // every fourth search returns the whole graph
    if (idx % 4 == 0) begin
      kv = K_W'(NV);
    end
    // query placed right on the entry vertex
    if (idx % 4 == 1) begin
      for (int d = 0; d < DIM; d++) begin
        q[d] = vertex_coord(ent, d);
      end
    end
    @(posedge clk_100mhz);
    start    <= 1'b1;
    entry_id <= ent;
    query    <= q;
    k        <= kv;
    @(posedge clk_100mhz);
    start <= 1'b0;
    @(posedge clk_100mhz);
    // busy by now, this start must not disturb the search
    draw_bits(32, r);
    start    <= 1'b1;
    entry_id <= ~ent;
    query    <= r;
    k        <= r[K_W-1:0];
    @(posedge clk_100mhz);
    start <= 1'b0;
    // search ends with done on its last result
    @(negedge clk_100mhz);
    while (!done) begin
      @(negedge clk_100mhz);
    end
  endtask

  task automatic check_result();
    int unsigned want;
    want = squared_l2(exp_query, result_id);
    results_seen++;
    assert (armed) else begin
      errors++;
      $display("result_valid at %0t with no search in progress", $time);
    end
    assert (result_dist == dist_t'(want))
      else log_mismatch($sformatf("vertex %0d distance %0d, expected %0d",
                                  result_id, result_dist, want));
    assert (!seen_ids[result_id])
      else log_mismatch($sformatf("vertex %0d returned twice", result_id));
    if (n_results > 0) begin
      assert (result_dist >= last_dist)
        else log_mismatch($sformatf("distance %0d after %0d", result_dist, last_dist));
    end
    // entry sits on the query, so it heads the list
    if (n_results == 0 && exact_query) begin
      assert (result_id == exp_entry && result_dist == '0)
        else log_mismatch($sformatf("first result %0d dist %0d, expected %0d dist 0",
                                    result_id, result_dist, exp_entry));
    end
    // done exactly on result number k
    assert (done == (n_results + 1 == exp_k))
      else log_mismatch($sformatf("done=%0b on result %0d of %0d", done, n_results + 1, exp_k));
    seen_ids[result_id] = 1'b1;
    last_dist           = result_dist;
    n_results++;
    if (done) begin
      if (exp_k == NV) begin
        assert (&seen_ids)
          else log_mismatch($sformatf("k=16 covered vertices %h", seen_ids));
      end
      armed = 1'b0;
      searches_done++;
    end
  endtask

  // sample away from the driving edge
  always @(negedge clk_100mhz) begin
    if (sys_rst) begin
      armed = 1'b0;
    end else begin
      // accepted start, latch what the search was asked
      if (start && !busy) begin
        armed       = 1'b1;
        exp_query   = query;
        exp_entry   = entry_id;
        exp_k       = k;
        n_results   = 0;
        seen_ids    = '0;
        exact_query = 1'b1;
        for (int d = 0; d < DIM; d++) begin
          if (query[d] != vertex_coord(entry_id, d)) begin
            exact_query = 1'b0;
          end
        end
      end
      if (result_valid) begin
        check_result();
      end
    end
  end

  initial begin
    errors        = 0;
    searches_done = 0;
    results_seen  = 0;
    lfsr          = 32'h38be4715;
    sys_rst  <= 1'b1;
    start    <= 1'b0;
    entry_id <= '0;
    query    <= '0;
    k        <= K_W'(1);
    repeat (4) @(posedge clk_100mhz);
    sys_rst <= 1'b0;
    repeat (3) @(posedge clk_100mhz);
    for (int unsigned s = 0; s < NUM_SEARCHES; s++) begin
      run_search(s);
    end
    repeat (2) @(posedge clk_100mhz);
    if (searches_done != NUM_SEARCHES) begin
      errors++;
      $display("only %0d of %0d searches ended with done", searches_done, NUM_SEARCHES);
    end
    $display("searches %0d, results %0d, errors %0d, assertion failures %0d",
             searches_done, results_seen, errors, dut.u_sva.fail_count);
    if (errors == 0 && dut.u_sva.fail_count == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  // all searches must finish within their cycle budget
  initial begin
    repeat (NUM_SEARCHES * SEARCH_BOUND) @(posedge clk_100mhz);
    $display("timeout after %0d cycles, the searches did not all finish",
             NUM_SEARCHES * SEARCH_BOUND);
    $display("Testbench failed");
    $finish;
  end

endmodule

// ==== compile.f ====
+incdir+verilog
verilog/graph_pkg.sv
verilog/search_pkg.sv
verilog/graph_rom.sv
verilog/l2_distance.sv
verilog/candidate_queue.sv
verilog/result_queue.sv
verilog/search_ctrl.sv
verilog/bfis.sv
verification/bfis_sva.sv
verification/bfis_tb.sv

// ==== Makefile ====
# Verilator flow for the bfis testbench
VERILATOR  ?= verilator
TOP        ?= bfis_tb
FILELIST   ?= compile.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
JOBS       ?= 0
EXTRA_ARGS ?=
# keep running past assertion errors so the closing report is printed
SIM_ARGS   ?= +verilator+error+limit+1000

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP) $(EXTRA_ARGS)

sim:
	$(VERILATOR) --binary --timing --assert -j $(JOBS) -Mdir $(BUILD_DIR) \
		-f $(FILELIST) --top-module $(TOP) $(EXTRA_ARGS)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	@grep -q "Testbench passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
